/* mips_id.f */
+incdir+.
mips_id_pkg.sv
id_control.sv
id_regfile.sv
id_imm_extend.sv
id_branch_unit.sv
id_ex_register.sv
id_stage.sv
tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ID stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_id_stage -f mips_id.f -o tb_id_stage
./obj_dir/tb_id_stage | tee sim.log
if grep -q "Everything OK" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

/* tb_id_model.svh */
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// one ID/EX slot as the model expects it
typedef struct packed {
   idex_data_t data;
   idex_ctrl_t ctrl;
} idex_entry_t;

word_t       model_regs [32];   // r0 entry never written
idex_entry_t idex_q [$];        // at most one entry in flight

function automatic word_t reg_value(input reg_num_t num);
   return (num == '0) ? '0 : model_regs[num];
endfunction

function automatic word_t extend_imm(input word_t instr);
   case (instr[31:26])
      OP_J, OP_JAL:                     return {6'b0, instr[25:0]};
      OP_ANDI, OP_ORI, OP_XORI, OP_LUI: return {16'b0, instr[15:0]};
      OP_SPECIAL:                       return {27'b0, instr[10:6]};   // shamt
      default:                          return {{16{instr[15]}}, instr[15:0]};
   endcase
endfunction

// one row of the decode table per opcode
function automatic idex_ctrl_t decode_ctrl(input word_t instr);
   idex_ctrl_t c;
   funct_t     fn;
   src_a_e     sp_a;
   fn = instr[5:0];
   if (fn == FN_JALR)
      sp_a = A_PC;
   else if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)
      sp_a = A_SHAMT;
   else
      sp_a = A_RS;
   case (instr[31:26])
      OP_JAL:     c = '{ALU_LINK, A_PC, B_IMM, DEST_R31, 1'b0, 1'b0};
      OP_ADDI:    c = '{ALU_ADD, A_RS, B_IMM, DEST_RT, 1'b0, 1'b0};
      OP_SLTI:    c = '{ALU_SLT, A_RS, B_IMM, DEST_RT, 1'b0, 1'b0};
      OP_ANDI:    c = '{ALU_AND, A_RS, B_IMM, DEST_RT, 1'b0, 1'b0};
      OP_ORI:     c = '{ALU_OR, A_RS, B_IMM, DEST_RT, 1'b0, 1'b0};
      OP_XORI:    c = '{ALU_XOR, A_RS, B_IMM, DEST_RT, 1'b0, 1'b0};
      OP_LUI:     c = '{ALU_LUI, A_NONE, B_IMM, DEST_RT, 1'b0, 1'b0};
      OP_LW:      c = '{ALU_ADD, A_RS, B_IMM, DEST_RT, 1'b1, 1'b0};
      OP_SW:      c = '{ALU_ADD, A_RS, B_IMM, DEST_RT, 1'b0, 1'b1};
      OP_SPECIAL: c = '{ALU_FUNC, sp_a, B_RT, DEST_RD, 1'b0, 1'b0};
      default:    c = '{ALU_NONE, A_NONE, B_IMM, DEST_RD, 1'b0, 1'b0};   // j, beq, bne, unknown
   endcase
   return c;
endfunction

function automatic redirect_t predict_redirect(input word_t pc, input word_t instr,
                                               input logic accepted);
   redirect_t r;
   opcode_t   op;
   word_t     rs;
   r  = '0;
   op = instr[31:26];
   rs = reg_value(instr[25:21]);
   if (!accepted)
      return r;
   if (op == OP_J || op == OP_JAL) begin
      r.jump      = 1'b1;
      r.jump_addr = {pc[31:28], instr[25:0], 2'b00};
   end else if (op == OP_SPECIAL && (instr[5:0] == FN_JR || instr[5:0] == FN_JALR)) begin
      r.jump      = 1'b1;
      r.jump_addr = rs;
   end
   if (op == OP_BEQ || op == OP_BNE) begin
      r.branch_addr  = pc + {{14{instr[15]}}, instr[15:0], 2'b00};
      r.branch_taken = (rs == reg_value(instr[20:16])) != (op == OP_BNE);
   end
   return r;
endfunction

// register values come from the model array at acceptance
function automatic idex_entry_t build_entry(input word_t pc, input word_t instr);
   idex_entry_t e;
   e.data = '{pc, reg_value(instr[25:21]), reg_value(instr[20:16]), extend_imm(instr),
              instr[5:0], instr[20:16], instr[15:11]};
   e.ctrl = decode_ctrl(instr);
   return e;
endfunction

`endif

/* tb_id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage import mips_id_pkg::*; ();

   localparam int N_INSTR        = 2000;
   localparam int TIMEOUT_CYCLES = N_INSTR * 10 + 100;
   localparam int NB_CHECK       = 160;   // wide enough for idex_data_t

   typedef logic [NB_CHECK-1:0] check_t;

   logic       i_clk;
   logic       i_rst;
   logic       i_instr_valid;
   logic       o_instr_ready;
   word_t      i_pc;
   word_t      i_instr;
   logic       i_wb_we;
   reg_num_t   i_wb_addr;
   word_t      i_wb_data;
   logic       o_idex_valid;
   logic       i_idex_ready;
   idex_data_t o_idex_data;
   idex_ctrl_t o_idex_ctrl;
   redirect_t  o_redirect;

   integer seed;
   int     cycle_count = 0;
   int     n_accepted;

   `include "tb_id_model.svh"

   id_stage i_id_stage (.*);

   always #10 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("[TIMEOUT] run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string name, input check_t expected, input check_t actual);
      if (expected !== actual) begin
         $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
         $display("Something failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   function automatic word_t random_instr();
      word_t   instr;
      opcode_t ops [14];
      int      pick;
      ops = '{OP_SPECIAL, OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDI, OP_SLTI,
              OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};
      instr = $random(seed);
      pick  = $unsigned($random(seed)) % 16;
      if (pick < 14)
         instr[31:26] = ops[pick];   // else keep a random, mostly unknown opcode
      if (instr[31:26] == OP_SPECIAL) begin
         pick = $unsigned($random(seed)) % 8;
         case (pick)
            0:       instr[5:0] = FN_SLL;
            1:       instr[5:0] = FN_SRL;
            2:       instr[5:0] = FN_SRA;
            3:       instr[5:0] = FN_JR;
            4:       instr[5:0] = FN_JALR;
            default: ;   // plain R-type funct
         endcase
      end
      // same rs and rt now and then, so beq / bne see both outcomes
      if ((instr[31:26] == OP_BEQ || instr[31:26] == OP_BNE) && $unsigned($random(seed)) % 4 == 0)
         instr[20:16] = instr[25:21];
      return instr;
   endfunction

   task automatic drive_inputs(input logic new_instr);
      if (new_instr) begin   // hold a waiting instruction
         i_instr_valid <= ($unsigned($random(seed)) % 10) < 7;
         i_instr       <= random_instr();
         i_pc          <= $random(seed) & 32'hffff_fffc;
      end
      i_idex_ready <= ($unsigned($random(seed)) % 10) < 6;
      i_wb_we      <= ($unsigned($random(seed)) % 10) < 3;
      i_wb_addr    <= reg_num_t'($random(seed));
      i_wb_data    <= (($random(seed) & 3) == 0) ? word_t'($random(seed) & 3) : $random(seed);
   endtask

   initial begin
      logic        valid_exp;
      logic        ready_exp;
      logic        accepted;
      logic        consumed;
      idex_entry_t entry;
      seed        = 32'h120f2ed0;
      n_accepted  = 0;
      foreach (model_regs[i]) model_regs[i] = '0;
      i_clk         = 1'b0;
      i_rst         = 1'b1;
      i_instr_valid = 1'b0;
      i_pc          = '0;
      i_instr       = '0;
      i_wb_we       = 1'b0;
      i_wb_addr     = '0;
      i_wb_data     = '0;
      i_idex_ready  = 1'b0;
      repeat (10) @(posedge i_clk);
      i_rst <= 1'b0;
      @(negedge i_clk);
      check_value("o_idex_valid", '0, check_t'(o_idex_valid));
      check_value("o_idex_data", '0, check_t'(o_idex_data));
      check_value("o_idex_ctrl", '0, check_t'(o_idex_ctrl));
      check_value("o_redirect", '0, check_t'(o_redirect));
      @(posedge i_clk);
      drive_inputs(1'b1);
      while (n_accepted < N_INSTR) begin
         @(negedge i_clk);   // inputs and outputs settled
         valid_exp = (idex_q.size() != 0);
         ready_exp = !valid_exp || i_idex_ready;
         accepted  = i_instr_valid && ready_exp;
         consumed  = valid_exp && i_idex_ready;
         check_value("o_idex_valid", check_t'(valid_exp), check_t'(o_idex_valid));
         check_value("o_instr_ready", check_t'(ready_exp), check_t'(o_instr_ready));
         check_value("o_redirect", check_t'(predict_redirect(i_pc, i_instr, accepted)),
                     check_t'(o_redirect));
         // queue head stays put under back-pressure, so this also covers the hold
         if (valid_exp) begin
            check_value("o_idex_data", check_t'(idex_q[0].data), check_t'(o_idex_data));
            check_value("o_idex_ctrl", check_t'(idex_q[0].ctrl), check_t'(o_idex_ctrl));
         end
         entry      = build_entry(i_pc, i_instr);
         @(posedge i_clk);
         if (consumed)
            void'(idex_q.pop_front());
         if (accepted) begin
            idex_q.push_back(entry);
            n_accepted++;
         end
         if (i_wb_we && i_wb_addr != '0)
            model_regs[i_wb_addr] = i_wb_data;   // after the read, so old value seen
         drive_inputs(accepted || !i_instr_valid);
      end
      @(negedge i_clk);
      check_value("o_idex_valid", 160'd1, check_t'(o_idex_valid));
      check_value("o_idex_data", check_t'(idex_q[0].data), check_t'(o_idex_data));
      check_value("o_idex_ctrl", check_t'(idex_q[0].ctrl), check_t'(o_idex_ctrl));
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage import mips_id_pkg::*; (
   input  wire             i_clk,
   input  wire             i_rst,
   // fetch side
   input  wire             i_instr_valid,
   output logic            o_instr_ready,
   input  wire word_t      i_pc,
   input  wire word_t      i_instr,
   // write-back port
   input  wire             i_wb_we,
   input  wire reg_num_t   i_wb_addr,
   input  wire word_t      i_wb_data,
   // execute side
   output logic            o_idex_valid,
   input  wire             i_idex_ready,
   output idex_data_t      o_idex_data,
   output idex_ctrl_t      o_idex_ctrl,
   output redirect_t       o_redirect
);

   // instruction fields
   opcode_t  opcode;
   funct_t   funct;
   reg_num_t rs_num;
   reg_num_t rt_num;
   reg_num_t rd_num;

   assign opcode = i_instr[31:26];
   assign rs_num = i_instr[25:21];
   assign rt_num = i_instr[20:16];
   assign rd_num = i_instr[15:11];
   assign funct  = i_instr[5:0];

   logic       accept;
   ext_kind_e  ext_kind;
   idex_ctrl_t ctrl;
   logic       is_branch;
   logic       is_bne;
   logic       is_jump_reg;
   logic       jump;
   word_t      rs_val;
   word_t      rt_val;
   logic       equal;
   word_t      imm;
   idex_data_t idex_next;

   id_control u_control (
      .i_opcode      (opcode),
      .i_funct       (funct),
      .i_instr_valid (i_instr_valid),
      .i_idex_ready  (i_idex_ready),
      .i_idex_valid  (o_idex_valid),
      .o_instr_ready (o_instr_ready),
      .o_accept      (accept),
      .o_ext_kind    (ext_kind),
      .o_ctrl        (ctrl),
      .o_is_branch   (is_branch),
      .o_is_bne      (is_bne),
      .o_is_jump_reg (is_jump_reg),
      .o_jump        (jump)
   );

   id_regfile u_regfile (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_num  (rs_num),
      .i_rt_num  (rt_num),
      .i_wr_en   (i_wb_we),
      .i_wr_num  (i_wb_addr),
      .i_wr_data (i_wb_data),
      .o_rs_val  (rs_val),
      .o_rt_val  (rt_val),
      .o_equal   (equal)
   );

   id_imm_extend u_imm_extend (
      .i_instr (i_instr),
      .i_kind  (ext_kind),
      .o_imm   (imm)
   );

   id_branch_unit u_branch_unit (
      .i_pc          (i_pc),
      .i_imm         (imm),
      .i_rs_val      (rs_val),
      .i_equal       (equal),
      .i_is_branch   (is_branch),
      .i_is_bne      (is_bne),
      .i_is_jump_reg (is_jump_reg),
      .i_jump        (jump),
      .o_redirect    (o_redirect)
   );

   assign idex_next = '{pc: i_pc, rs_val: rs_val, rt_val: rt_val, imm: imm,
                        funct: funct, rt_num: rt_num, rd_num: rd_num};

   id_ex_register u_id_ex_register (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_load       (accept),
      .i_idex_ready (i_idex_ready),
      .i_data       (idex_next),
      .i_ctrl       (ctrl),
      .o_valid      (o_idex_valid),
      .o_data       (o_idex_data),
      .o_ctrl       (o_idex_ctrl)
   );

endmodule

`default_nettype wire

/* id_ex_register.sv */
`timescale 1ns/1ns
`default_nettype none

module id_ex_register import mips_id_pkg::*; (
   input  wire             i_clk,
   input  wire             i_rst,
   input  wire             i_load,
   input  wire             i_idex_ready,
   input  wire idex_data_t i_data,
   input  wire idex_ctrl_t i_ctrl,
   output logic            o_valid,
   output idex_data_t      o_data,
   output idex_ctrl_t      o_ctrl
);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_valid <= 1'b0;
      end else if (i_load) begin
         o_valid <= 1'b1;
      end else if (o_valid && i_idex_ready) begin   // consumed, nothing new
         o_valid <= 1'b0;
      end
   end

   // payload only moves on a load, holds under back-pressure
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_data <= '0;
         o_ctrl <= '0;
      end else if (i_load) begin
         o_data <= i_data;
         o_ctrl <= i_ctrl;
      end
   end

endmodule

`default_nettype wire

/* id_branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module id_branch_unit import mips_id_pkg::*; (
   input  wire word_t i_pc,
   input  wire word_t i_imm,
   input  wire word_t i_rs_val,
   input  wire        i_equal,
   input  wire        i_is_branch,
   input  wire        i_is_bne,
   input  wire        i_is_jump_reg,
   input  wire        i_jump,
   output redirect_t  o_redirect
);

   word_t branch_target;
   word_t jump_target;

   // offset relative to the pc of the branch itself
   assign branch_target = i_pc + (i_imm << 2);

   // region jump keeps pc[31:28], jr / jalr go to rs
   assign jump_target = i_is_jump_reg ? i_rs_val
                      : {i_pc[NB_WORD-1:NB_INDEX+2], i_imm[NB_INDEX-1:0], 2'b00};

   always_comb begin
      o_redirect.jump         = i_jump;
      o_redirect.branch_taken = i_is_branch && (i_equal != i_is_bne);
      // addresses forced to zero when their enable is off
      o_redirect.jump_addr    = i_jump ? jump_target : '0;
      o_redirect.branch_addr  = i_is_branch ? branch_target : '0;
   end

endmodule

`default_nettype wire

/* id_imm_extend.sv */
`timescale 1ns/1ns
`default_nettype none

module id_imm_extend import mips_id_pkg::*; (
   input  wire word_t     i_instr,
   input  wire ext_kind_e i_kind,
   output word_t          o_imm
);

   logic [NB_IMM-1:0]   imm16;
   logic [NB_INDEX-1:0] index;
   logic [NB_SHAMT-1:0] shamt;

   assign imm16 = i_instr[NB_IMM-1:0];
   assign index = i_instr[NB_INDEX-1:0];
   assign shamt = i_instr[SHAMT_LSB+NB_SHAMT-1:SHAMT_LSB];   // bits 10:6

   always_comb begin
      case (i_kind)
         EXT_INDEX: o_imm = {{(NB_WORD-NB_INDEX){1'b0}}, index};
         EXT_SIGN:  o_imm = {{(NB_WORD-NB_IMM){imm16[NB_IMM-1]}}, imm16};
         EXT_ZERO:  o_imm = {{(NB_WORD-NB_IMM){1'b0}}, imm16};
         default:   o_imm = {{(NB_WORD-NB_SHAMT){1'b0}}, shamt};
      endcase
   end

endmodule

`default_nettype wire

/* id_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module id_regfile import mips_id_pkg::*; (
   input  wire        i_clk,
   input  wire        i_rst,
   input  wire reg_num_t i_rs_num,
   input  wire reg_num_t i_rt_num,
   input  wire        i_wr_en,
   input  wire reg_num_t i_wr_num,
   input  wire word_t i_wr_data,
   output word_t      o_rs_val,
   output word_t      o_rt_val,
   output logic       o_equal
);

   word_t regs [N_REGS];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && (i_wr_num != '0)) begin   // r0 stays zero
         regs[i_wr_num] <= i_wr_data;
      end
   end

   // async read, no write bypass
   assign o_rs_val = (i_rs_num == '0) ? '0 : regs[i_rs_num];
   assign o_rt_val = (i_rt_num == '0) ? '0 : regs[i_rt_num];

   assign o_equal = (o_rs_val == o_rt_val);   // beq / bne compare

endmodule

`default_nettype wire

/* id_control.sv */
`timescale 1ns/1ns
`default_nettype none

module id_control import mips_id_pkg::*; (
   input  wire opcode_t    i_opcode,
   input  wire funct_t     i_funct,
   input  wire             i_instr_valid,
   input  wire             i_idex_ready,
   input  wire             i_idex_valid,
   output logic            o_instr_ready,
   output logic            o_accept,
   output ext_kind_e       o_ext_kind,
   output idex_ctrl_t      o_ctrl,
   output logic            o_is_branch,
   output logic            o_is_bne,
   output logic            o_is_jump_reg,
   output logic            o_jump
);

   logic dec_branch;   // beq or bne
   logic dec_bne;
   logic dec_jump;     // any jump, not yet qualified

   // free slot when ID/EX is empty or drains this cycle
   assign o_instr_ready = !i_idex_valid || i_idex_ready;
   assign o_accept      = i_instr_valid && o_instr_ready;

   always_comb begin
      // row for unknown opcodes, doubles as the default
      o_ext_kind       = EXT_SIGN;
      o_ctrl.alu_op    = ALU_NONE;
      o_ctrl.src_a     = A_NONE;
      o_ctrl.src_b     = B_IMM;
      o_ctrl.dest_sel  = DEST_RD;
      o_ctrl.mem_read  = 1'b0;
      o_ctrl.mem_write = 1'b0;
      dec_branch       = 1'b0;
      dec_bne          = 1'b0;
      dec_jump         = 1'b0;
      o_is_jump_reg    = 1'b0;

      case (i_opcode)
         OP_J: begin
            o_ext_kind = EXT_INDEX;
            dec_jump   = 1'b1;
         end
         OP_JAL: begin
            o_ext_kind      = EXT_INDEX;
            o_ctrl.alu_op   = ALU_LINK;
            o_ctrl.src_a    = A_PC;
            o_ctrl.dest_sel = DEST_R31;   // link register
            dec_jump        = 1'b1;
         end
         OP_BEQ: dec_branch = 1'b1;
         OP_BNE: begin
            dec_branch = 1'b1;
            dec_bne    = 1'b1;
         end
         OP_ADDI, OP_SLTI, OP_LW, OP_SW: begin
            o_ctrl.alu_op    = (i_opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
            o_ctrl.src_a     = A_RS;
            o_ctrl.dest_sel  = DEST_RT;
            o_ctrl.mem_read  = (i_opcode == OP_LW);
            o_ctrl.mem_write = (i_opcode == OP_SW);   // rt is store data here
         end
         OP_ANDI, OP_ORI, OP_XORI: begin
            o_ext_kind      = EXT_ZERO;
            o_ctrl.src_a    = A_RS;
            o_ctrl.dest_sel = DEST_RT;
            case (i_opcode)
               OP_ANDI: o_ctrl.alu_op = ALU_AND;
               OP_ORI:  o_ctrl.alu_op = ALU_OR;
               default: o_ctrl.alu_op = ALU_XOR;
            endcase
         end
         OP_LUI: begin
            o_ext_kind      = EXT_ZERO;
            o_ctrl.alu_op   = ALU_LUI;
            o_ctrl.dest_sel = DEST_RT;
         end
         OP_SPECIAL: begin
            o_ext_kind    = EXT_SHAMT;
            o_ctrl.alu_op = ALU_FUNC;
            o_ctrl.src_b  = B_RT;
            case (i_funct)
               FN_JALR:                o_ctrl.src_a = A_PC;
               FN_SLL, FN_SRL, FN_SRA: o_ctrl.src_a = A_SHAMT;
               default:                o_ctrl.src_a = A_RS;
            endcase
            o_is_jump_reg = (i_funct == FN_JR) || (i_funct == FN_JALR);
            dec_jump      = o_is_jump_reg;
         end
         default: ;
      endcase
   end

   // redirects only for an instruction that is really taken in
   assign o_jump      = o_accept && dec_jump;
   assign o_is_branch = o_accept && dec_branch;
   assign o_is_bne    = o_accept && dec_bne;

endmodule

`default_nettype wire

/* mips_id_pkg.sv */
`default_nettype none

package mips_id_pkg;

   // widths
   localparam int NB_WORD   = 32;
   localparam int NB_REG    = 5;
   localparam int NB_FIELD  = 6;   // opcode and funct
   localparam int NB_IMM    = 16;
   localparam int NB_INDEX  = 26;
   localparam int NB_SHAMT  = 5;
   localparam int SHAMT_LSB = 6;
   localparam int N_REGS    = 32;

   typedef logic [NB_WORD-1:0]  word_t;
   typedef logic [NB_REG-1:0]   reg_num_t;
   typedef logic [NB_FIELD-1:0] opcode_t;
   typedef logic [NB_FIELD-1:0] funct_t;

   // primary opcodes, instr[31:26]
   localparam opcode_t OP_SPECIAL = 6'd0;
   localparam opcode_t OP_J       = 6'd2;
   localparam opcode_t OP_JAL     = 6'd3;
   localparam opcode_t OP_BEQ     = 6'd4;
   localparam opcode_t OP_BNE     = 6'd5;
   localparam opcode_t OP_ADDI    = 6'd8;
   localparam opcode_t OP_SLTI    = 6'd10;
   localparam opcode_t OP_ANDI    = 6'd12;
   localparam opcode_t OP_ORI     = 6'd13;
   localparam opcode_t OP_XORI    = 6'd14;
   localparam opcode_t OP_LUI     = 6'd15;
   localparam opcode_t OP_LW      = 6'd35;
   localparam opcode_t OP_SW      = 6'd43;

   // SPECIAL functs that decode needs to see
   localparam funct_t FN_SLL  = 6'd0;
   localparam funct_t FN_SRL  = 6'd2;
   localparam funct_t FN_SRA  = 6'd3;
   localparam funct_t FN_JR   = 6'd8;
   localparam funct_t FN_JALR = 6'd9;

   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_LUI  = 4'd6,
      ALU_FUNC = 4'd7,   // execute looks at funct
      ALU_LINK = 4'd8    // return address for jal / jalr
   } alu_op_e;

   typedef enum logic [1:0] {A_PC, A_RS, A_SHAMT, A_NONE} src_a_e;
   typedef enum logic {B_RT, B_IMM} src_b_e;
   typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_R31} dest_sel_e;
   typedef enum logic [1:0] {EXT_INDEX, EXT_SIGN, EXT_ZERO, EXT_SHAMT} ext_kind_e;

   typedef struct packed {
      alu_op_e   alu_op;
      src_a_e    src_a;
      src_b_e    src_b;
      dest_sel_e dest_sel;
      logic      mem_read;
      logic      mem_write;
   } idex_ctrl_t;

   typedef struct packed {
      word_t    pc;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      funct_t   funct;
      reg_num_t rt_num;
      reg_num_t rd_num;
   } idex_data_t;

   typedef struct packed {
      logic  jump;
      logic  branch_taken;
      word_t jump_addr;
      word_t branch_addr;
   } redirect_t;

endpackage

`default_nettype wire
